// ==== hw/simtCore_config.svh ====
`ifndef SIMT_CORE_CONFIG_SVH
`define SIMT_CORE_CONFIG_SVH

// Warps sharing one issue slot
`define SIMT_NUM_WARPS 8

// Architectural registers per warp
`define SIMT_NUM_REGS 32

// Register and ALU width
`define SIMT_DATA_WIDTH 32

`endif

// ==== hw/simtCorePkg.sv ====
`include "simtCore_config.svh"

package simtCorePkg;

	typedef logic [31:0] instrT;
	typedef logic [`SIMT_DATA_WIDTH-1:0] dataT;
	typedef logic [31:0] addrT;
	typedef logic [$clog2(`SIMT_NUM_REGS)-1:0] regIdxT;
	typedef logic [`SIMT_NUM_WARPS-1:0] warpMaskT; // One-hot warp select
	typedef logic [$clog2(`SIMT_NUM_WARPS)-1:0] warpIdT;
	typedef logic [3:0] aluOpT;

	// R-type operations, in funct table order
	localparam aluOpT aluAdd = 4'd0;
	localparam aluOpT aluSub = 4'd1;
	localparam aluOpT aluMul = 4'd2;
	localparam aluOpT aluAnd = 4'd3;
	localparam aluOpT aluOr = 4'd4;
	localparam aluOpT aluXor = 4'd5;
	localparam aluOpT aluShr = 4'd6;
	localparam aluOpT aluShl = 4'd7;
	localparam aluOpT aluAddImm = 4'd8; // Immediate forms
	localparam aluOpT aluAndImm = 4'd9;
	localparam aluOpT aluOrImm = 4'd10;
	localparam aluOpT aluXorImm = 4'd11;

	// One-hot mask to warp number
	function automatic warpIdT toWarpId(input warpMaskT mask);
		warpIdT id;
		id = '0;
		for (int i = 0; i < `SIMT_NUM_WARPS; i++) begin
			if (mask[i]) begin
				id = id | warpIdT'(i);
			end
		end
		return id;
	endfunction

endpackage

// ==== hw/instrDecode.sv ====
module instrDecode (
	input  simtCorePkg::instrT    instr,
	input  simtCorePkg::addrT     pcPlus4,
	input  simtCorePkg::warpMaskT warpValid,
	output simtCorePkg::warpMaskT jumpWarps,
	output simtCorePkg::addrT     jumpTarget,
	output simtCorePkg::warpMaskT decWarps,
	output simtCorePkg::regIdxT   decSrc1,
	output simtCorePkg::regIdxT   decSrc2,
	output simtCorePkg::regIdxT   decDst,
	output simtCorePkg::dataT     decImm,
	output simtCorePkg::aluOpT    decAluOp,
	output logic                  decRegWrite,
	output logic                  decUseImm,
	output logic                  decBeq,
	output logic                  decBlt,
	output logic                  decExit,
	output simtCorePkg::addrT     decPcPlus4
);
	import simtCorePkg::*;

	logic [5:0] opcode;
	logic [5:0] opBase;
	logic [5:0] funct;
	logic [15:0] imm16;
	regIdxT rs;
	regIdxT rt;
	regIdxT rd;
	logic isRType;
	logic isAddi;
	logic isAndi;
	logic isOri;
	logic isXori;
	logic isBeq;
	logic isBlt;
	logic isJump;
	logic isCall;
	logic isExit;
	logic zeroExt;
	logic functKnown;
	aluOpT functOp;

	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign funct = instr[5:0];
	assign imm16 = instr[15:0];

	// Bit 4 copies decode like the base opcode
	assign opBase = {opcode[5], 1'b0, opcode[3:0]};

	assign isRType = (opBase == 6'b000000); // Integer
	assign isAddi = (opBase == 6'b001000);
	assign isAndi = (opBase == 6'b001100);
	assign isOri = (opBase == 6'b001101);
	assign isXori = (opBase == 6'b001110);
	assign isBeq = (opBase == 6'b000100);
	assign isBlt = (opBase == 6'b000111);
	assign isJump = (opBase == 6'b000010); // J and 010010
	assign isCall = (opcode == 6'b000011);
	assign isExit = (opcode == 6'b100001);

	// Funct table, R-type only
	always_comb begin
		functKnown = 1'b1;
		case (funct)
			6'b100000: functOp = aluAdd;
			6'b100010: functOp = aluSub;
			6'b011000: functOp = aluMul;
			6'b100100: functOp = aluAnd;
			6'b100101: functOp = aluOr;
			6'b100110: functOp = aluXor;
			6'b000010: functOp = aluShr;
			6'b000000: functOp = aluShl;
			default: begin
				functOp = aluAdd;
				functKnown = 1'b0; // No write below
			end
		endcase
	end

	always_comb begin
		if (isAddi) begin
			decAluOp = aluAddImm;
		end else if (isAndi) begin
			decAluOp = aluAndImm;
		end else if (isOri) begin
			decAluOp = aluOrImm;
		end else if (isXori) begin
			decAluOp = aluXorImm;
		end else begin
			decAluOp = functOp;
		end
	end

	// Logic immediates zero-extend, ADDI and branches sign-extend
	assign zeroExt = isAndi | isOri | isXori;
	assign decImm = zeroExt ? dataT'(imm16) : dataT'(signed'(imm16));

	assign decUseImm = isAddi | zeroExt;
	assign decRegWrite = (isRType & functKnown) | decUseImm; // Memory ops and RET fall out here
	assign decSrc1 = rs;
	assign decSrc2 = rt;
	assign decDst = isRType ? rd : rt;
	assign decBeq = isBeq;
	assign decBlt = isBlt;
	assign decExit = isExit;
	assign decWarps = warpValid;
	assign decPcPlus4 = pcPlus4;

	// CALL behaves as a plain jump
	assign jumpWarps = (isJump | isCall) ? warpValid : '0;
	assign jumpTarget = addrT'(instr[25:0]);

endmodule

// ==== hw/warpRegFile.sv ====
`include "simtCore_config.svh"

module warpRegFile (
	input  logic                clk,
	input  logic                rstN,
	input  simtCorePkg::warpIdT rdWarp,
	input  simtCorePkg::regIdxT rdIdx1,
	input  simtCorePkg::regIdxT rdIdx2,
	output simtCorePkg::dataT   rdData1,
	output simtCorePkg::dataT   rdData2,
	input  logic                wrEn,
	input  simtCorePkg::warpIdT wrWarp,
	input  simtCorePkg::regIdxT wrIdx,
	input  simtCorePkg::dataT   wrData
);
	import simtCorePkg::*;

	dataT regs [`SIMT_NUM_WARPS][`SIMT_NUM_REGS]; // One bank per warp

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int w = 0; w < `SIMT_NUM_WARPS; w++) begin
				for (int r = 0; r < `SIMT_NUM_REGS; r++) begin
					regs[w][r] <= '0;
				end
			end
		end else if (wrEn && wrIdx != '0) begin
			regs[wrWarp][wrIdx] <= wrData; // r0 stays zero
		end
	end

	// Read ports see the old value on a same-cycle write
	assign rdData1 = (rdIdx1 == '0) ? '0 : regs[rdWarp][rdIdx1];
	assign rdData2 = (rdIdx2 == '0) ? '0 : regs[rdWarp][rdIdx2];

endmodule

// ==== hw/aluExecute.sv ====
module aluExecute (
	input  logic                  clk,
	input  logic                  rstN,
	input  simtCorePkg::warpMaskT decWarps,
	input  simtCorePkg::regIdxT   decSrc1,
	input  simtCorePkg::regIdxT   decSrc2,
	input  simtCorePkg::regIdxT   decDst,
	input  simtCorePkg::dataT     decImm,
	input  simtCorePkg::aluOpT    decAluOp,
	input  logic                  decRegWrite,
	input  logic                  decUseImm,
	input  logic                  decBeq,
	input  logic                  decBlt,
	input  logic                  decExit,
	input  simtCorePkg::addrT     decPcPlus4,
	input  simtCorePkg::warpMaskT exitedWarps,
	output simtCorePkg::warpIdT   rdWarp,
	output simtCorePkg::regIdxT   rdIdx1,
	output simtCorePkg::regIdxT   rdIdx2,
	input  simtCorePkg::dataT     rdData1,
	input  simtCorePkg::dataT     rdData2,
	input  logic                  fwdEn,
	input  simtCorePkg::warpIdT   fwdWarp,
	input  simtCorePkg::regIdxT   fwdIdx,
	input  simtCorePkg::dataT     fwdData,
	output simtCorePkg::warpMaskT exWarps,
	output simtCorePkg::regIdxT   exDst,
	output simtCorePkg::dataT     exData,
	output logic                  exRegWrite,
	output logic                  exBranchTaken,
	output simtCorePkg::addrT     exBranchTarget,
	output logic                  exExit
);
	import simtCorePkg::*;

	warpMaskT liveWarps;
	logic issueValid;
	regIdxT exSrc1;
	regIdxT exSrc2;
	dataT exImm;
	aluOpT exAluOp;
	logic exUseImm;
	logic exBeq;
	logic exBlt;
	addrT exPcPlus4;
	dataT src1Val;
	dataT src2Val;
	dataT opB;
	dataT aluResult;

	// Drop warps that exited, including an EXIT still in this stage
	assign liveWarps = decWarps & ~exitedWarps & ~(exExit ? exWarps : '0);
	assign issueValid = |liveWarps;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exWarps <= '0;
			exRegWrite <= 1'b0;
			exBeq <= 1'b0;
			exBlt <= 1'b0;
			exExit <= 1'b0;
		end else begin
			exWarps <= liveWarps;
			exRegWrite <= decRegWrite & issueValid;
			exBeq <= decBeq & issueValid;
			exBlt <= decBlt & issueValid;
			exExit <= decExit & issueValid;
		end
	end

	always_ff @(posedge clk) begin
		exSrc1 <= decSrc1;
		exSrc2 <= decSrc2;
		exDst <= decDst;
		exImm <= decImm;
		exAluOp <= decAluOp;
		exUseImm <= decUseImm;
		exPcPlus4 <= decPcPlus4;
	end

	assign rdWarp = toWarpId(exWarps);
	assign rdIdx1 = exSrc1;
	assign rdIdx2 = exSrc2;

	// Bypass from the result stage, same warp only
	assign src1Val = (fwdEn && fwdWarp == rdWarp && fwdIdx == exSrc1 && exSrc1 != '0) ?
		fwdData : rdData1;
	assign src2Val = (fwdEn && fwdWarp == rdWarp && fwdIdx == exSrc2 && exSrc2 != '0) ?
		fwdData : rdData2;

	assign opB = exUseImm ? exImm : src2Val;

	always_comb begin
		case (exAluOp)
			aluAdd, aluAddImm: aluResult = src1Val + opB;
			aluSub: aluResult = src1Val - opB;
			aluMul: aluResult = src1Val * opB; // Low half only
			aluAnd, aluAndImm: aluResult = src1Val & opB;
			aluOr, aluOrImm: aluResult = src1Val | opB;
			aluXor, aluXorImm: aluResult = src1Val ^ opB;
			aluShr: aluResult = src1Val >> opB[4:0];
			aluShl: aluResult = src1Val << opB[4:0];
			default: aluResult = src1Val + opB;
		endcase
	end

	assign exData = aluResult;

	assign exBranchTaken = (exBeq && src1Val == src2Val)
		|| (exBlt && $signed(src1Val) < $signed(src2Val));
	assign exBranchTarget = exPcPlus4 + (addrT'(exImm) << 2); // Word offset

endmodule

// ==== hw/resultCommit.sv ====
module resultCommit (
	input  logic                  clk,
	input  logic                  rstN,
	input  simtCorePkg::warpMaskT exWarps,
	input  simtCorePkg::regIdxT   exDst,
	input  simtCorePkg::dataT     exData,
	input  logic                  exRegWrite,
	input  logic                  exBranchTaken,
	input  simtCorePkg::addrT     exBranchTarget,
	input  logic                  exExit,
	output logic                  resultValid,
	output simtCorePkg::warpIdT   resultWarp,
	output simtCorePkg::regIdxT   resultDst,
	output simtCorePkg::dataT     resultData,
	output simtCorePkg::warpMaskT branchWarps,
	output simtCorePkg::addrT     branchTarget,
	output simtCorePkg::warpMaskT exitedWarps,
	output logic                  wrEn,
	output simtCorePkg::warpIdT   wrWarp,
	output simtCorePkg::regIdxT   wrIdx,
	output simtCorePkg::dataT     wrData
);
	import simtCorePkg::*;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resultValid <= 1'b0;
			branchWarps <= '0;
			exitedWarps <= '0;
		end else begin
			resultValid <= exRegWrite;
			branchWarps <= exBranchTaken ? exWarps : '0;
			exitedWarps <= exitedWarps | (exExit ? exWarps : '0); // Sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		resultWarp <= toWarpId(exWarps);
		resultDst <= exDst;
		resultData <= exData;
		branchTarget <= exBranchTarget;
	end

	// Shared by write-back and the execute bypass
	assign wrEn = resultValid && resultDst != '0;
	assign wrWarp = resultWarp;
	assign wrIdx = resultDst;
	assign wrData = resultData;

endmodule

// ==== hw/simtCore.sv ====
module simtCore (
	input  logic                  clk,
	input  logic                  rstN,
	input  simtCorePkg::instrT    instr,
	input  simtCorePkg::addrT     pcPlus4,
	input  simtCorePkg::warpMaskT warpValid,
	output simtCorePkg::warpMaskT jumpWarps,
	output simtCorePkg::addrT     jumpTarget,
	output logic                  resultValid,
	output simtCorePkg::warpIdT   resultWarp,
	output simtCorePkg::regIdxT   resultDst,
	output simtCorePkg::dataT     resultData,
	output simtCorePkg::warpMaskT branchWarps,
	output simtCorePkg::addrT     branchTarget,
	output simtCorePkg::warpMaskT exitedWarps
);
	import simtCorePkg::*;

	warpMaskT decWarps;
	regIdxT decSrc1;
	regIdxT decSrc2;
	regIdxT decDst;
	dataT decImm;
	aluOpT decAluOp;
	logic decRegWrite;
	logic decUseImm;
	logic decBeq;
	logic decBlt;
	logic decExit;
	addrT decPcPlus4;
	warpIdT rdWarp;
	regIdxT rdIdx1;
	regIdxT rdIdx2;
	dataT rdData1;
	dataT rdData2;
	warpMaskT exWarps;
	regIdxT exDst;
	dataT exData;
	logic exRegWrite;
	logic exBranchTaken;
	addrT exBranchTarget;
	logic exExit;
	logic wrEn;
	warpIdT wrWarp;
	regIdxT wrIdx;
	dataT wrData;

	instrDecode instrDecode_inst (
		.instr(instr),
		.pcPlus4(pcPlus4),
		.warpValid(warpValid),
		.jumpWarps(jumpWarps),
		.jumpTarget(jumpTarget),
		.decWarps(decWarps),
		.decSrc1(decSrc1),
		.decSrc2(decSrc2),
		.decDst(decDst),
		.decImm(decImm),
		.decAluOp(decAluOp),
		.decRegWrite(decRegWrite),
		.decUseImm(decUseImm),
		.decBeq(decBeq),
		.decBlt(decBlt),
		.decExit(decExit),
		.decPcPlus4(decPcPlus4)
	);

	warpRegFile warpRegFile_inst (
		.clk(clk),
		.rstN(rstN),
		.rdWarp(rdWarp),
		.rdIdx1(rdIdx1),
		.rdIdx2(rdIdx2),
		.rdData1(rdData1),
		.rdData2(rdData2),
		.wrEn(wrEn),
		.wrWarp(wrWarp),
		.wrIdx(wrIdx),
		.wrData(wrData)
	);

	aluExecute aluExecute_inst (
		.clk(clk),
		.rstN(rstN),
		.decWarps(decWarps),
		.decSrc1(decSrc1),
		.decSrc2(decSrc2),
		.decDst(decDst),
		.decImm(decImm),
		.decAluOp(decAluOp),
		.decRegWrite(decRegWrite),
		.decUseImm(decUseImm),
		.decBeq(decBeq),
		.decBlt(decBlt),
		.decExit(decExit),
		.decPcPlus4(decPcPlus4),
		.exitedWarps(exitedWarps),
		.rdWarp(rdWarp),
		.rdIdx1(rdIdx1),
		.rdIdx2(rdIdx2),
		.rdData1(rdData1),
		.rdData2(rdData2),
		.fwdEn(wrEn), // Bypass taps the write port
		.fwdWarp(wrWarp),
		.fwdIdx(wrIdx),
		.fwdData(wrData),
		.exWarps(exWarps),
		.exDst(exDst),
		.exData(exData),
		.exRegWrite(exRegWrite),
		.exBranchTaken(exBranchTaken),
		.exBranchTarget(exBranchTarget),
		.exExit(exExit)
	);

	resultCommit resultCommit_inst (
		.clk(clk),
		.rstN(rstN),
		.exWarps(exWarps),
		.exDst(exDst),
		.exData(exData),
		.exRegWrite(exRegWrite),
		.exBranchTaken(exBranchTaken),
		.exBranchTarget(exBranchTarget),
		.exExit(exExit),
		.resultValid(resultValid),
		.resultWarp(resultWarp),
		.resultDst(resultDst),
		.resultData(resultData),
		.branchWarps(branchWarps),
		.branchTarget(branchTarget),
		.exitedWarps(exitedWarps),
		.wrEn(wrEn),
		.wrWarp(wrWarp),
		.wrIdx(wrIdx),
		.wrData(wrData)
	);

endmodule

// ==== tb/simtCoreTb.sv ====
`include "simtCore_config.svh"

module simtCoreTb;
	timeunit 1ns;
	timeprecision 1ps;
	import simtCorePkg::*;

	localparam int resetCycles = 4;
	localparam int aluCycles = 48;
	localparam int fwdCycles = 14;
	localparam int jumpCycles = 67;
	localparam int branchCycles = 33;
	localparam int killCycles = 30;
	localparam int cycleLimit = resetCycles + aluCycles + fwdCycles + jumpCycles
		+ branchCycles + killCycles + 50;

	logic clk;
	logic rstN;
	instrT instr;
	addrT pcPlus4;
	warpMaskT warpValid;
	warpMaskT jumpWarps;
	addrT jumpTarget;
	logic resultValid;
	warpIdT resultWarp;
	regIdxT resultDst;
	dataT resultData;
	warpMaskT branchWarps;
	addrT branchTarget;
	warpMaskT exitedWarps;

	dataT model [`SIMT_NUM_WARPS][`SIMT_NUM_REGS]; // Expected register contents
	warpMaskT exitedModel;
	logic [31:0] lcgState;
	int errors;
	int cycles = 0;

	simtCore simtCore_inst (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.pcPlus4(pcPlus4),
		.warpValid(warpValid),
		.jumpWarps(jumpWarps),
		.jumpTarget(jumpTarget),
		.resultValid(resultValid),
		.resultWarp(resultWarp),
		.resultDst(resultDst),
		.resultData(resultData),
		.branchWarps(branchWarps),
		.branchTarget(branchTarget),
		.exitedWarps(exitedWarps)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout: the tests ran past %0d cycles", cycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic dataT lcgNext();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	function automatic warpMaskT warpMask(input int w);
		return warpMaskT'(1) << w;
	endfunction

	function automatic dataT signExt(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic dataT zeroExt(input logic [15:0] imm);
		return {16'b0, imm};
	endfunction

	function automatic instrT encodeR(input regIdxT rs, input regIdxT rt, input regIdxT rd,
		input logic [5:0] funct);
		return {6'b0, rs, rt, rd, 5'b0, funct};
	endfunction

	function automatic instrT encodeI(input logic [5:0] op, input regIdxT rs, input regIdxT rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Integer funct table
	function automatic dataT refAlu(input logic [5:0] funct, input dataT a, input dataT b);
		case (funct)
			6'h20: return a + b;
			6'h22: return a - b;
			6'h18: return a * b;
			6'h24: return a & b;
			6'h25: return a | b;
			6'h26: return a ^ b;
			6'h02: return a >> b[4:0];
			6'h00: return a << b[4:0];
			default: return '0;
		endcase
	endfunction

	task automatic checkData(input string name, input dataT got, input dataT want);
		if (got !== want) begin
			errors++;
			$display("error: %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic checkMask(input string name, input warpMaskT got, input warpMaskT want);
		if (got !== want) begin
			errors++;
			$display("error: %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic checkAddr(input string name, input addrT got, input addrT want);
		if (got !== want) begin
			errors++;
			$display("error: %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic checkReg(input string name, input regIdxT got, input regIdxT want);
		if (got !== want) begin
			errors++;
			$display("error: %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic checkWarp(input string name, input warpIdT got, input warpIdT want);
		if (got !== want) begin
			errors++;
			$display("error: %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic want);
		if (got !== want) begin
			errors++;
			$display("error: %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic driveSlot(input instrT word, input warpMaskT mask, input addrT pc);
		@(posedge clk);
		instr <= word;
		warpValid <= mask;
		pcPlus4 <= pc;
	endtask

	task automatic clearSlot();
		@(posedge clk);
		instr <= '0;
		warpValid <= '0;
	endtask

	task automatic expectResult(input int warp, input regIdxT dst, input dataT want);
		checkFlag("resultValid", resultValid, 1'b1);
		checkWarp("resultWarp", resultWarp, warpIdT'(warp));
		checkReg("resultDst", resultDst, dst);
		checkData("resultData", resultData, want);
		if (dst != '0) begin
			model[warp][dst] = want;
		end
	endtask

	task automatic runAlu(input instrT word, input int warp, input regIdxT dst, input dataT want);
		driveSlot(word, warpMask(warp), 32'h100);
		clearSlot();
		@(posedge clk);
		@(negedge clk); // Two edges after issue
		expectResult(warp, dst, want);
	endtask

	task automatic runPair(input instrT wordA, input int warpA, input regIdxT dstA,
		input dataT wantA, input instrT wordB, input int warpB, input regIdxT dstB,
		input dataT wantB);
		driveSlot(wordA, warpMask(warpA), 32'h100);
		driveSlot(wordB, warpMask(warpB), 32'h104);
		clearSlot();
		@(negedge clk);
		expectResult(warpA, dstA, wantA);
		@(posedge clk);
		@(negedge clk);
		expectResult(warpB, dstB, wantB);
	endtask

	task automatic expectNone(input instrT word, input int warp);
		driveSlot(word, warpMask(warp), 32'h100);
		clearSlot();
		@(posedge clk);
		@(negedge clk);
		checkFlag("resultValid", resultValid, 1'b0);
		checkMask("branchWarps", branchWarps, '0);
	endtask

	task automatic runBranch(input logic [5:0] op, input regIdxT rs, input regIdxT rt,
		input logic [15:0] imm, input addrT pc);
		dataT a;
		dataT b;
		logic taken;
		addrT target;
		a = model[4][rs];
		b = model[4][rt];
		if (op[3:0] == 4'h7) begin
			taken = $signed(a) < $signed(b); // BLT
		end else begin
			taken = (a == b);
		end
		target = pc + (signExt(imm) << 2);
		driveSlot(encodeI(op, rs, rt, imm), warpMask(4), pc);
		clearSlot();
		@(posedge clk);
		@(negedge clk);
		checkFlag("resultValid", resultValid, 1'b0);
		checkMask("branchWarps", branchWarps, taken ? warpMask(4) : '0);
		if (taken) begin
			checkAddr("branchTarget", branchTarget, target);
		end
	endtask

	task automatic testAlu();
		logic [5:0] functs [8];
		logic [15:0] imm;
		dataT rnd;
		functs = '{6'h20, 6'h22, 6'h18, 6'h24, 6'h25, 6'h26, 6'h02, 6'h00};
		for (int r = 1; r <= 4; r++) begin
			rnd = lcgNext();
			imm = {r[0], rnd[14:0]}; // Odd registers negative, even ones positive
			runAlu(encodeI(6'h08, 5'd0, regIdxT'(r), imm), 3, regIdxT'(r), signExt(imm));
		end
		for (int i = 0; i < 8; i++) begin
			runAlu(encodeR(5'd1, 5'd2, regIdxT'(10 + i), functs[i]), 3, regIdxT'(10 + i),
				refAlu(functs[i], model[3][1], model[3][2]));
		end
		rnd = lcgNext();
		imm = {1'b1, rnd[14:0]}; // Top bit set to expose the extension
		runAlu(encodeI(6'h0C, 5'd3, 5'd20, imm), 3, 5'd20, model[3][3] & zeroExt(imm));
		runAlu(encodeI(6'h0D, 5'd4, 5'd21, imm), 3, 5'd21, model[3][4] | zeroExt(imm));
		runAlu(encodeI(6'h0E, 5'd3, 5'd22, imm), 3, 5'd22, model[3][3] ^ zeroExt(imm));
		runAlu(encodeI(6'h18, 5'd4, 5'd23, imm), 3, 5'd23, model[3][4] + signExt(imm));
	endtask

	task automatic testForward();
		logic [15:0] imm;
		dataT rnd;
		dataT v1;
		rnd = lcgNext();
		imm = rnd[15:0];
		runAlu(encodeI(6'h08, 5'd0, 5'd5, imm), 5, 5'd5, signExt(imm));
		rnd = lcgNext();
		imm = rnd[15:0];
		v1 = signExt(imm);
		runPair(encodeI(6'h08, 5'd0, 5'd5, imm), 0, 5'd5, v1,
			encodeR(5'd5, 5'd5, 5'd6, 6'h20), 0, 5'd6, v1 + v1);
		// Same index in warp 5 must ignore the warp 0 bypass
		runPair(encodeI(6'h08, 5'd5, 5'd5, 16'h0001), 0, 5'd5, v1 + 32'd1,
			encodeR(5'd5, 5'd0, 5'd7, 6'h20), 5, 5'd7, model[5][5]);
		runAlu(encodeR(5'd5, 5'd0, 5'd8, 6'h20), 0, 5'd8, model[0][5]);
	endtask

	task automatic testJump();
		logic [5:0] opc;
		logic jump;
		dataT rnd;
		for (int op = 0; op < 64; op++) begin
			opc = op[5:0];
			rnd = lcgNext();
			driveSlot({opc, rnd[25:0]}, warpMask(7), 32'h200);
			@(negedge clk);
			jump = (opc == 6'h02) || (opc == 6'h12) || (opc == 6'h03);
			checkMask("jumpWarps", jumpWarps, jump ? warpMask(7) : '0);
			if (jump) begin
				checkAddr("jumpTarget", jumpTarget, {6'b0, rnd[25:0]});
			end
			if (opc == 6'h21) begin
				exitedModel = exitedModel | warpMask(7); // EXIT is in the sweep
			end
		end
		clearSlot();
		@(posedge clk);
		@(posedge clk);
	endtask

	task automatic testBranch();
		runAlu(encodeI(6'h08, 5'd0, 5'd1, 16'h0005), 4, 5'd1, 32'd5);
		runAlu(encodeI(6'h08, 5'd0, 5'd2, 16'h0005), 4, 5'd2, 32'd5);
		runAlu(encodeI(6'h08, 5'd0, 5'd3, 16'hFFFD), 4, 5'd3, signExt(16'hFFFD));
		runAlu(encodeI(6'h08, 5'd0, 5'd4, 16'h0007), 4, 5'd4, 32'd7);
		runBranch(6'h04, 5'd1, 5'd2, 16'h0010, 32'h1000);
		runBranch(6'h04, 5'd1, 5'd4, 16'h0020, 32'h1000);
		runBranch(6'h07, 5'd3, 5'd1, 16'hFFF0, 32'h2000); // Negative below positive
		runBranch(6'h07, 5'd1, 5'd3, 16'h0004, 32'h2000);
		runBranch(6'h07, 5'd1, 5'd4, 16'h0008, 32'h3000);
		runBranch(6'h14, 5'd3, 5'd3, 16'h8000, 32'h4000);
		runBranch(6'h17, 5'd4, 5'd3, 16'h0001, 32'h5000);
	endtask

	task automatic testKill();
		expectNone(encodeI(6'h23, 5'd1, 5'd9, 16'h0040), 1);
		expectNone(encodeI(6'h33, 5'd1, 5'd9, 16'h0040), 1);
		expectNone(encodeI(6'h2B, 5'd1, 5'd9, 16'h0040), 1);
		expectNone(encodeI(6'h3B, 5'd1, 5'd9, 16'h0040), 1);
		expectNone(encodeR(5'd1, 5'd2, 5'd9, 6'h3F), 1);
		expectNone(encodeR(5'd1, 5'd2, 5'd9, 6'h01), 1);
		runAlu(encodeR(5'd9, 5'd0, 5'd11, 6'h20), 1, 5'd11, model[1][9]);
		expectNone(encodeI(6'h21, 5'd0, 5'd0, 16'h0000), 2);
		exitedModel = exitedModel | warpMask(2);
		checkMask("exitedWarps", exitedWarps, exitedModel);
		expectNone(encodeI(6'h08, 5'd0, 5'd6, 16'h1234), 2);
		runAlu(encodeI(6'h08, 5'd0, 5'd6, 16'h1234), 1, 5'd6, 32'h1234);
		checkMask("exitedWarps", exitedWarps, exitedModel);
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		instr = '0;
		pcPlus4 = '0;
		warpValid = '0;
		errors = 0;
		lcgState = 32'd4;
		exitedModel = '0;
		for (int w = 0; w < `SIMT_NUM_WARPS; w++) begin
			for (int r = 0; r < `SIMT_NUM_REGS; r++) begin
				model[w][r] = '0;
			end
		end
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkFlag("resultValid", resultValid, 1'b0);
		checkMask("branchWarps", branchWarps, '0);
		checkMask("jumpWarps", jumpWarps, '0);
		checkMask("exitedWarps", exitedWarps, '0);
		testAlu();
		testForward();
		testJump();
		testBranch();
		testKill();
		@(posedge clk);
		$display("Checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/simtCorePkg.sv
hw/instrDecode.sv
hw/warpRegFile.sv
hw/aluExecute.sv
hw/resultCommit.sv
hw/simtCore.sv
tb/simtCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f filelist.f --top-module simtCoreTb -o simtCoreSim \
	&& ./obj_dir/simtCoreSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or run did not complete"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
